// File: include/unified_cache_defs.svh
`ifndef UNIFIED_CACHE_DEFS_SVH
`define UNIFIED_CACHE_DEFS_SVH

// Word address, one word per block.
`define UC_ADDR_WIDTH 16
`define UC_BLOCK_WIDTH 32

// Two-way set associative with eight sets.
`define UC_NUMBER_WAYS 2
`define UC_NUMBER_SETS 8
`define UC_SET_PTR_WIDTH 3

// Upper address bits above the set index.
`define UC_TAG_WIDTH (`UC_ADDR_WIDTH - `UC_SET_PTR_WIDTH)

`endif

// File: src/cache_types_pkg.sv
`include "unified_cache_defs.svh"

package cache_types_pkg;

        typedef logic [`UC_ADDR_WIDTH - 1 : 0]    addr_t;    // {tag, set}.
        typedef logic [`UC_TAG_WIDTH - 1 : 0]     tag_t;
        typedef logic [`UC_SET_PTR_WIDTH - 1 : 0] set_ptr_t;
        typedef logic [`UC_BLOCK_WIDTH - 1 : 0]   block_t;
        typedef logic [`UC_NUMBER_WAYS - 1 : 0]   way_sel_t; // One-hot.

        typedef struct packed
        {
                logic valid;
                logic dirty;
                tag_t tag;
        } tag_entry_t;

        // One entry per way, way 0 in the low bits.
        typedef tag_entry_t [`UC_NUMBER_WAYS - 1 : 0] tag_pack_t;

        typedef struct packed
        {
                logic   write;
                addr_t  addr;
                block_t data;
        } cache_request_t;

        typedef struct packed
        {
                block_t data;
        } cache_response_t;

endpackage

// File: src/mem_bus_pkg.sv
package mem_bus_pkg;

        import cache_types_pkg::*;

        // Write-back or refill toward memory.
        typedef struct packed
        {
                logic   write;
                addr_t  addr;
                block_t data;
        } mem_request_t;

        typedef struct packed
        {
                block_t data;  // Valid while mem_ack is high.
        } mem_response_t;

endpackage

// File: src/tag_array.sv
`timescale 1ns/1ps
`include "unified_cache_defs.svh"

module tag_array import cache_types_pkg::*;
(
        input  logic       clk_in,
        input  logic       reset_in,
        input  logic       tag_read_en,
        input  set_ptr_t   tag_read_set_addr,
        output tag_pack_t  tag_read_pack,
        output way_sel_t   victim_way,
        input  logic       tag_write_en,
        input  set_ptr_t   tag_write_set_addr,
        input  way_sel_t   tag_way_select,
        input  tag_entry_t tag_write
);

way_sel_t valid_q [`UC_NUMBER_SETS];
way_sel_t dirty_q [`UC_NUMBER_SETS];
tag_t     tag_q   [`UC_NUMBER_SETS][`UC_NUMBER_WAYS];
logic [$clog2(`UC_NUMBER_WAYS) - 1 : 0] rr_ptr [`UC_NUMBER_SETS];
logic     refill;

// A refill replaces the line or fills an empty one.
always_comb
begin
        refill = 1'b0;
        for (int w = 0; w < `UC_NUMBER_WAYS; w++)
        begin
                if (tag_way_select[w] && (!valid_q[tag_write_set_addr][w] ||
                    tag_q[tag_write_set_addr][w] != tag_write.tag))
                        refill = 1'b1;
        end
end

always_ff @(posedge clk_in or posedge reset_in)
begin
        if (reset_in)
        begin
                for (int s = 0; s < `UC_NUMBER_SETS; s++)
                begin
                        valid_q[s] <= '0;
                        dirty_q[s] <= '0;
                        rr_ptr[s]  <= '0;
                end
                tag_read_pack <= '0;
                victim_way    <= '0;
        end
        else
        begin
                if (tag_read_en)
                begin
                        for (int w = 0; w < `UC_NUMBER_WAYS; w++)
                        begin
                                tag_read_pack[w].valid <= valid_q[tag_read_set_addr][w];
                                tag_read_pack[w].dirty <= dirty_q[tag_read_set_addr][w];
                                tag_read_pack[w].tag   <= tag_q[tag_read_set_addr][w];
                        end
                        victim_way <= way_sel_t'(1) << rr_ptr[tag_read_set_addr];
                end
                if (tag_write_en)
                begin
                        for (int w = 0; w < `UC_NUMBER_WAYS; w++)
                        begin
                                if (tag_way_select[w])
                                begin
                                        valid_q[tag_write_set_addr][w] <= tag_write.valid;
                                        dirty_q[tag_write_set_addr][w] <= tag_write.dirty;
                                end
                        end
                        if (refill)
                        begin
                                if (32'(rr_ptr[tag_write_set_addr]) == `UC_NUMBER_WAYS - 1)
                                        rr_ptr[tag_write_set_addr] <= '0;  // Wrap to way 0.
                                else
                                        rr_ptr[tag_write_set_addr] <= rr_ptr[tag_write_set_addr] + 1'b1;
                        end
                end
        end
end

always_ff @(posedge clk_in)
begin
        if (tag_write_en)
        begin
                for (int w = 0; w < `UC_NUMBER_WAYS; w++)
                begin
                        if (tag_way_select[w])
                                tag_q[tag_write_set_addr][w] <= tag_write.tag;
                end
        end
end

endmodule

// File: src/data_array.sv
`timescale 1ns/1ps
`include "unified_cache_defs.svh"

module data_array import cache_types_pkg::*;
(
        input  logic     clk_in,
        input  way_sel_t data_way_select,
        input  logic     data_read_en,
        input  set_ptr_t data_read_set_addr,
        output block_t   data_read_data,
        input  logic     data_write_en,
        input  set_ptr_t data_write_set_addr,
        input  block_t   data_write
);

block_t blocks [`UC_NUMBER_SETS][`UC_NUMBER_WAYS];
block_t read_mux;

// One-hot way select, so an OR of the masked ways.
always_comb
begin
        read_mux = '0;
        for (int w = 0; w < `UC_NUMBER_WAYS; w++)
        begin
                if (data_way_select[w])
                        read_mux = read_mux | blocks[data_read_set_addr][w];
        end
end

always_ff @(posedge clk_in)
begin
        if (data_read_en)
                data_read_data <= read_mux;  // Registered read port.
end

always_ff @(posedge clk_in)
begin
        if (data_write_en)
        begin
                for (int w = 0; w < `UC_NUMBER_WAYS; w++)
                begin
                        if (data_way_select[w])
                                blocks[data_write_set_addr][w] <= data_write;
                end
        end
end

endmodule

// File: src/main_ctrl.sv
`timescale 1ns/1ps
`include "unified_cache_defs.svh"

module main_ctrl import cache_types_pkg::*, mem_bus_pkg::*;
(
        input  logic            clk_in,
        input  logic            reset_in,
        input  cache_request_t  request,
        input  logic            req,
        output cache_response_t response,
        output logic            ack,
        output mem_request_t    mem_request,
        output logic            mem_req,
        input  mem_response_t   mem_response,
        input  logic            mem_ack,
        output logic            tag_read_en,
        output set_ptr_t        tag_read_set_addr,
        input  tag_pack_t       tag_read_pack,
        input  way_sel_t        victim_way,
        output logic            tag_write_en,
        output set_ptr_t        tag_write_set_addr,
        output way_sel_t        tag_way_select,
        output tag_entry_t      tag_write,
        output way_sel_t        data_way_select,
        output logic            data_read_en,
        output set_ptr_t        data_read_set_addr,
        input  block_t          data_read_data,
        output logic            data_write_en,
        output set_ptr_t        data_write_set_addr,
        output block_t          data_write
);

typedef enum logic [3:0]
{
        S_IDLE, S_LOOKUP, S_HIT, S_HIT_RESP,
        S_WB_READ, S_WB_DATA, S_WB_REQ, S_WB_REL,
        S_RF_REQ, S_RF_REL, S_FILL, S_DONE
} ctrl_state_t;

ctrl_state_t    state;
cache_request_t stage2;       // Request under lookup.
way_sel_t       way_sel;      // Hit way, or victim on a miss.
tag_t           victim_tag;
block_t         fill_data;
set_ptr_t       req_set;
tag_t           req_tag;
way_sel_t       hit_way;
logic           hit;
tag_entry_t     victim_entry;
logic           wb_needed;
logic           issue_rf;

assign req_set = stage2.addr[`UC_SET_PTR_WIDTH - 1 : 0];
assign req_tag = stage2.addr[`UC_ADDR_WIDTH - 1 : `UC_SET_PTR_WIDTH];

always_comb
begin
        hit_way      = '0;
        victim_entry = '0;
        for (int w = 0; w < `UC_NUMBER_WAYS; w++)
        begin
                hit_way[w] = tag_read_pack[w].valid && (tag_read_pack[w].tag == req_tag);
                if (victim_way[w])
                        victim_entry = tag_read_pack[w];
        end
end

assign hit       = |hit_way;
assign wb_needed = victim_entry.valid && victim_entry.dirty;
assign issue_rf  = ((state == S_LOOKUP) && !hit && !wb_needed) ||
                   ((state == S_WB_REL) && !mem_ack);

// Tag read goes out on the edge that first sees req.
assign tag_read_en       = (state == S_IDLE) && req;
assign tag_read_set_addr = request.addr[`UC_SET_PTR_WIDTH - 1 : 0];

assign tag_write_en       = ((state == S_HIT) && stage2.write) || (state == S_FILL);
assign tag_write_set_addr = req_set;
assign tag_way_select     = way_sel;
assign tag_write.valid    = 1'b1;
assign tag_write.dirty    = stage2.write;  // Read refill leaves the line clean.
assign tag_write.tag      = req_tag;

assign data_way_select     = way_sel;
assign data_read_en        = ((state == S_HIT) && !stage2.write) || (state == S_WB_READ);
assign data_read_set_addr  = req_set;
assign data_write_en       = tag_write_en;
assign data_write_set_addr = req_set;
assign data_write          = stage2.write ? stage2.data : fill_data;

always_ff @(posedge clk_in or posedge reset_in)
begin
        if (reset_in)
        begin
                state   <= S_IDLE;
                ack     <= 1'b0;
                mem_req <= 1'b0;
                way_sel <= '0;
        end
        else
        begin
                case (state)
                        S_IDLE:
                                if (req)
                                        state <= S_LOOKUP;
                        S_LOOKUP:
                        begin
                                if (hit)
                                begin
                                        way_sel <= hit_way;
                                        state   <= S_HIT;
                                end
                                else
                                begin
                                        way_sel <= victim_way;
                                        mem_req <= !wb_needed;
                                        state   <= wb_needed ? S_WB_READ : S_RF_REQ;
                                end
                        end
                        S_HIT:      state <= S_HIT_RESP;
                        S_HIT_RESP:
                        begin
                                ack   <= 1'b1;
                                state <= S_DONE;
                        end
                        S_WB_READ:  state <= S_WB_DATA;
                        S_WB_DATA:
                        begin
                                mem_req <= 1'b1;  // Victim data now valid.
                                state   <= S_WB_REQ;
                        end
                        S_WB_REQ:
                                if (mem_ack)
                                begin
                                        mem_req <= 1'b0;
                                        state   <= S_WB_REL;
                                end
                        S_WB_REL:
                                if (!mem_ack)
                                begin
                                        mem_req <= 1'b1;
                                        state   <= S_RF_REQ;
                                end
                        S_RF_REQ:
                                if (mem_ack)
                                begin
                                        mem_req <= 1'b0;
                                        state   <= S_RF_REL;
                                end
                        S_RF_REL:
                                if (!mem_ack)
                                        state <= S_FILL;
                        S_FILL:
                        begin
                                ack   <= 1'b1;
                                state <= S_DONE;
                        end
                        S_DONE:
                                if (!req)
                                begin
                                        ack   <= 1'b0;
                                        state <= S_IDLE;
                                end
                        default:    state <= S_IDLE;
                endcase
        end
end

always_ff @(posedge clk_in)
begin
        if ((state == S_IDLE) && req)
                stage2 <= request;
        if (state == S_LOOKUP)
                victim_tag <= victim_entry.tag;
        if ((state == S_RF_REQ) && mem_ack)
                fill_data <= mem_response.data;
        if (state == S_HIT_RESP)
                response.data <= stage2.write ? stage2.data : data_read_data;
        if (state == S_FILL)
                response.data <= stage2.write ? stage2.data : fill_data;
        if (state == S_WB_DATA)
        begin
                mem_request.write <= 1'b1;
                mem_request.addr  <= {victim_tag, req_set};  // Evicted line's address.
                mem_request.data  <= data_read_data;
        end
        else if (issue_rf)
        begin
                mem_request.write <= 1'b0;
                mem_request.addr  <= stage2.addr;
                mem_request.data  <= '0;
        end
end

endmodule

// File: src/unified_cache.sv
`timescale 1ns/1ps

module unified_cache import cache_types_pkg::*, mem_bus_pkg::*;
(
        input  logic            clk_in,
        input  logic            reset_in,
        input  cache_request_t  request,
        input  logic            req,
        output cache_response_t response,
        output logic            ack,
        output mem_request_t    mem_request,
        output logic            mem_req,
        input  mem_response_t   mem_response,
        input  logic            mem_ack
);

logic       tag_read_en;
set_ptr_t   tag_read_set_addr;
tag_pack_t  tag_read_pack;
way_sel_t   victim_way;
logic       tag_write_en;
set_ptr_t   tag_write_set_addr;
way_sel_t   tag_way_select;
tag_entry_t tag_write;
way_sel_t   data_way_select;
logic       data_read_en;
set_ptr_t   data_read_set_addr;
block_t     data_read_data;
logic       data_write_en;
set_ptr_t   data_write_set_addr;
block_t     data_write;

main_ctrl u_main_ctrl
(
        .clk_in              (clk_in),
        .reset_in            (reset_in),
        .request             (request),
        .req                 (req),
        .response            (response),
        .ack                 (ack),
        .mem_request         (mem_request),
        .mem_req             (mem_req),
        .mem_response        (mem_response),
        .mem_ack             (mem_ack),
        .tag_read_en         (tag_read_en),
        .tag_read_set_addr   (tag_read_set_addr),
        .tag_read_pack       (tag_read_pack),
        .victim_way          (victim_way),
        .tag_write_en        (tag_write_en),
        .tag_write_set_addr  (tag_write_set_addr),
        .tag_way_select      (tag_way_select),
        .tag_write           (tag_write),
        .data_way_select     (data_way_select),
        .data_read_en        (data_read_en),
        .data_read_set_addr  (data_read_set_addr),
        .data_read_data      (data_read_data),
        .data_write_en       (data_write_en),
        .data_write_set_addr (data_write_set_addr),
        .data_write          (data_write)
);

tag_array u_tag_array
(
        .clk_in              (clk_in),
        .reset_in            (reset_in),
        .tag_read_en         (tag_read_en),
        .tag_read_set_addr   (tag_read_set_addr),
        .tag_read_pack       (tag_read_pack),
        .victim_way          (victim_way),
        .tag_write_en        (tag_write_en),
        .tag_write_set_addr  (tag_write_set_addr),
        .tag_way_select      (tag_way_select),
        .tag_write           (tag_write)
);

data_array u_data_array
(
        .clk_in              (clk_in),
        .data_way_select     (data_way_select),
        .data_read_en        (data_read_en),
        .data_read_set_addr  (data_read_set_addr),
        .data_read_data      (data_read_data),
        .data_write_en       (data_write_en),
        .data_write_set_addr (data_write_set_addr),
        .data_write          (data_write)
);

endmodule

// File: sim/unified_cache_assertions.sv
`timescale 1ns/1ps

module unified_cache_assertions import mem_bus_pkg::*;
(
        input logic         clk_in,
        input logic         reset_in,
        input logic         req,
        input logic         ack,
        input logic         mem_req,
        input logic         mem_ack,
        input mem_request_t mem_request
);

int unsigned failures = 0;
logic [7:0]  req_edges;  // Edges that saw req high while ack was low.

always_ff @(posedge clk_in or posedge reset_in)
begin
        if (reset_in)
                req_edges <= '0;
        else if (!req)
                req_edges <= '0;
        else if (!ack && (req_edges != 8'hff))
                req_edges <= req_edges + 8'd1;
end

assert property (@(posedge clk_in) $past(reset_in) |-> !ack && !mem_req)
else
begin
        $error("ack or mem_req high right after reset");
        failures++;
end

assert property (@(posedge clk_in) disable iff (reset_in) ack && req |=> ack)
else
begin
        $error("ack dropped while req was still high");
        failures++;
end

assert property (@(posedge clk_in) disable iff (reset_in) ack && !req |=> !ack)
else
begin
        $error("ack did not fall one cycle after req fell");
        failures++;
end

assert property (@(posedge clk_in) disable iff (reset_in) mem_req && !mem_ack |=> mem_req)
else
begin
        $error("mem_req dropped before mem_ack");
        failures++;
end

assert property (@(posedge clk_in) disable iff (reset_in)
        mem_req && $past(mem_req) |-> $stable(mem_request))
else
begin
        $error("mem_request changed while mem_req was high");
        failures++;
end

// A hit takes E0 to E3, so ack never shows up before four such edges.
assert property (@(posedge clk_in) disable iff (reset_in) $rose(ack) |-> req_edges >= 8'd4)
else
begin
        $error("ack rose earlier than the lookup latency allows");
        failures++;
end

endmodule

// File: sim/unified_cache_tb.sv
`timescale 1ns/1ps
`include "unified_cache_defs.svh"

module unified_cache_tb import cache_types_pkg::*, mem_bus_pkg::*;
();

localparam int MEM_WORDS   = 1 << `UC_ADDR_WIDTH;
localparam int ACK_TIMEOUT = 100;
localparam int MEM_TIMEOUT = 50;

logic            clk_in;
logic            reset_in;
cache_request_t  request;
logic            req;
cache_response_t response;
logic            ack;
mem_request_t    mem_request;
logic            mem_req;
mem_response_t   mem_response;
logic            mem_ack;

block_t      shadow      [MEM_WORDS];  // Architectural view.
block_t      backing_mem [MEM_WORDS];  // What memory really holds.
logic [31:0] stim_lfsr;
logic [31:0] mem_lfsr;
int unsigned mem_reads;
int unsigned mem_writes;
int unsigned mem_seq;
int unsigned last_write_seq;
int unsigned last_read_seq;
addr_t       last_wb_addr;
block_t      last_wb_data;

unified_cache dut
(
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .request      (request),
        .req          (req),
        .response     (response),
        .ack          (ack),
        .mem_request  (mem_request),
        .mem_req      (mem_req),
        .mem_response (mem_response),
        .mem_ack      (mem_ack)
);

bind unified_cache unified_cache_assertions u_checks
(
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .req         (req),
        .ack         (ack),
        .mem_req     (mem_req),
        .mem_ack     (mem_ack),
        .mem_request (mem_request)
);

task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
endtask

task automatic expect_equal(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        assert (got === expected)
        else
                abort_run($sformatf("ERR %s got %h expected %h", name, got, expected));
endtask

// Galois LFSR, one step per bit taken.
task automatic draw_bits(inout logic [31:0] state, input int count,
                         output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
                value = {value[30:0], state[0]};
                state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
        end
endtask

task automatic serve_mem_request();
        mem_seq++;
        if (mem_request.write)
        begin
                backing_mem[mem_request.addr] = mem_request.data;
                last_wb_addr   = mem_request.addr;
                last_wb_data   = mem_request.data;
                last_write_seq = mem_seq;
                mem_writes++;
        end
        else
        begin
                mem_response.data = backing_mem[mem_request.addr];
                last_read_seq     = mem_seq;
                mem_reads++;
        end
        mem_ack = 1'b1;
endtask

// One full four-phase access; latency counts edges after E0 until ack.
task automatic run_access(input logic is_write, input addr_t addr, input block_t data,
                          output int latency);
        int     waited;
        block_t expected;
        expected = is_write ? data : shadow[addr];
        if (is_write)
                shadow[addr] = data;
        request.write = is_write;
        request.addr  = addr;
        request.data  = data;
        req           = 1'b1;
        waited        = 0;
        do
        begin
                @(negedge clk_in);
                waited++;
                if (waited > ACK_TIMEOUT)
                        abort_run("timeout waiting for ack to rise");
        end
        while (!ack);
        latency = waited - 1;
        expect_equal("response.data", response.data, expected);
        req    = 1'b0;
        waited = 0;
        do
        begin
                @(negedge clk_in);
                waited++;
                if (waited > ACK_TIMEOUT)
                        abort_run("timeout waiting for ack to fall");
        end
        while (ack);
endtask

initial
begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
end

// Memory model with a random 0 to 3 cycle ack delay.
initial
begin
        int          phase;
        int          delay_left;
        int          hold;
        logic [31:0] bits;
        mem_ack        = 1'b0;
        mem_response   = '0;
        mem_lfsr       = 32'h8da12c20;
        mem_reads      = 0;
        mem_writes     = 0;
        mem_seq        = 0;
        last_write_seq = 0;
        last_read_seq  = 0;
        last_wb_addr   = '0;
        last_wb_data   = '0;
        for (int i = 0; i < MEM_WORDS; i++)
                backing_mem[addr_t'(i)] = 32'(i) ^ 32'hc0de0000;
        phase      = 0;
        delay_left = 0;
        hold       = 0;
        forever
        begin
                @(negedge clk_in);
                if ((phase == 0) && mem_req && !reset_in)
                begin
                        draw_bits(mem_lfsr, 2, bits);
                        delay_left = int'(bits);
                        phase      = 1;
                end
                if (phase == 1)
                begin
                        if (delay_left == 0)
                        begin
                                serve_mem_request();
                                hold  = 0;
                                phase = 2;
                        end
                        else
                                delay_left--;
                end
                else if (phase == 2)
                begin
                        if (!mem_req)
                        begin
                                mem_ack = 1'b0;  // Release phase.
                                phase   = 0;
                        end
                        else
                        begin
                                hold++;
                                if (hold > MEM_TIMEOUT)
                                        abort_run("mem_req was never released after mem_ack");
                        end
                end
        end
end

initial
begin
        forever
        begin
                @(negedge clk_in);
                if (dut.u_checks.failures != 0)
                        abort_run("a bound handshake assertion failed");
        end
end

initial
begin
        int          latency;
        int unsigned reads_before;
        int unsigned writes_before;
        logic [31:0] bits;
        logic        is_write;
        addr_t       addr;
        block_t      data;
        block_t      first_data;
        reset_in  = 1'b1;
        req       = 1'b0;
        request   = '0;
        stim_lfsr = 32'h8da12c20;
        for (int i = 0; i < MEM_WORDS; i++)
                shadow[addr_t'(i)] = 32'(i) ^ 32'hc0de0000;
        repeat (4) @(negedge clk_in);
        reset_in = 1'b0;
        @(negedge clk_in);

        reads_before  = mem_reads;
        writes_before = mem_writes;
        run_access(1'b0, 16'h0040, '0, latency);  // Cold read miss.
        expect_equal("mem read handshakes", mem_reads - reads_before, 32'd1);
        expect_equal("mem write handshakes", mem_writes - writes_before, 32'd0);

        reads_before  = mem_reads;
        writes_before = mem_writes;
        run_access(1'b0, 16'h0040, '0, latency);  // Same line, now a hit.
        expect_equal("mem handshakes on hit", (mem_reads + mem_writes) -
                     (reads_before + writes_before), 32'd0);
        expect_equal("ack latency", latency, 32'd3);

        run_access(1'b1, 16'h0051, 32'h1234abcd, latency);
        run_access(1'b0, 16'h0051, '0, latency);
        expect_equal("ack latency", latency, 32'd3);

        draw_bits(stim_lfsr, 32, first_data);
        draw_bits(stim_lfsr, 32, data);
        run_access(1'b1, 16'h0105, first_data, latency);
        run_access(1'b1, 16'h0205, data, latency);
        draw_bits(stim_lfsr, 32, data);
        reads_before  = mem_reads;
        writes_before = mem_writes;
        run_access(1'b1, 16'h0305, data, latency);  // Evicts the dirty 0x0105 line.
        expect_equal("mem write handshakes", mem_writes - writes_before, 32'd1);
        expect_equal("mem read handshakes", mem_reads - reads_before, 32'd1);
        expect_equal("mem_request.addr", 32'(last_wb_addr), 32'h00000105);
        expect_equal("mem_request.data", last_wb_data, first_data);
        assert (last_write_seq < last_read_seq)
        else
                abort_run("write-back did not come before the refill");
        run_access(1'b0, 16'h0105, '0, latency);

        // Four tags per set across 32 words keeps the victims cycling.
        for (int n = 0; n < 200; n++)
        begin
                draw_bits(stim_lfsr, 1, bits);
                is_write = bits[0];
                draw_bits(stim_lfsr, 5, bits);
                addr = {11'h020, bits[4:0]};
                data = '0;
                if (is_write)
                        draw_bits(stim_lfsr, 32, data);
                run_access(is_write, addr, data, latency);
        end

        $display("test passed");
        $finish;
end

endmodule

// File: unified_cache.f
+incdir+include
src/cache_types_pkg.sv
src/mem_bus_pkg.sv
src/tag_array.sv
src/data_array.sv
src/main_ctrl.sv
src/unified_cache.sv
sim/unified_cache_assertions.sv
sim/unified_cache_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module unified_cache_tb \
        -f unified_cache.f \
        -Mdir obj_dir

./obj_dir/Vunified_cache_tb
